// File: include/initTable.svh
/*
 * LCD controller initialisation table
 * Command bytes carry regSelect low, their parameters carry it high
 */
`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

localparam initEntry initRom [initLength] = '{
    // Undocumented vendor setup
    {1'b0, 8'hEF}, {1'b1, 8'h03}, {1'b1, 8'h80}, {1'b1, 8'h02},
    // Power control B
    {1'b0, 8'hCF}, {1'b1, 8'h00}, {1'b1, 8'h81}, {1'b1, 8'hC0},
    // Power on sequence
    {1'b0, 8'hED}, {1'b1, 8'h64}, {1'b1, 8'h03}, {1'b1, 8'h12},
    {1'b1, 8'h81},
    // Driver timing A
    {1'b0, 8'hE8}, {1'b1, 8'h85}, {1'b1, 8'h01}, {1'b1, 8'h78},
    // Power control A
    {1'b0, 8'hCB}, {1'b1, 8'h39}, {1'b1, 8'h2C}, {1'b1, 8'h00},
    {1'b1, 8'h34}, {1'b1, 8'h02},
    {1'b0, 8'hF7}, {1'b1, 8'h20},                  // Pump ratio
    {1'b0, 8'hEA}, {1'b1, 8'h00}, {1'b1, 8'h00},   // Driver timing B
    {1'b0, 8'hC0}, {1'b1, 8'h23},                  // Power control 1
    {1'b0, 8'hC1}, {1'b1, 8'h10},                  // Power control 2
    {1'b0, 8'hC5}, {1'b1, 8'h3E}, {1'b1, 8'h28},   // VCOM control 1
    {1'b0, 8'hC7}, {1'b1, 8'h86},                  // VCOM control 2
    {1'b0, 8'h36}, {1'b1, 8'h48},                  // Memory access order
    {1'b0, 8'h3A}, {1'b1, 8'h55},                  // 16 bits per pixel
    {1'b0, 8'hB1}, {1'b1, 8'h00}, {1'b1, 8'h1B},   // Frame rate
    // Display function control
    {1'b0, 8'hB6}, {1'b1, 8'h08}, {1'b1, 8'h82}, {1'b1, 8'h27},
    {1'b0, 8'hF2}, {1'b1, 8'h00},                  // 3-gamma off
    {1'b0, 8'h26}, {1'b1, 8'h01},                  // Gamma curve 1
    {1'b0, 8'hB1}, {1'b1, 8'h00}, {1'b1, 8'h01},   // Frame rate again
    // Interface control
    {1'b0, 8'hF6}, {1'b1, 8'h01}, {1'b1, 8'h10}, {1'b1, 8'h00},
    {1'b0, 8'h11},                                 // Sleep out
    // Full-screen column window
    {1'b0, cmdColumnSet}, {1'b1, 8'h00}, {1'b1, 8'h00},
    {1'b1, 8'((screenWidth - 1) >> 8)},
    {1'b1, 8'(screenWidth - 1)},
    // Full-screen row window
    {1'b0, cmdRowSet}, {1'b1, 8'h00}, {1'b1, 8'h00},
    {1'b1, 8'((screenHeight - 1) >> 8)},
    {1'b1, 8'(screenHeight - 1)},
    {1'b0, 8'h29}                                  // Display on
};

`endif

// File: hdl/lcdPkg.sv
/*
 * Shared definitions for the LCD driver
 * Screen geometry, bus and table types, command codes and FSM encodings
 */
package lcdPkg;

    localparam int screenWidth  = 240;    // Columns
    localparam int screenHeight = 320;    // Rows

    typedef logic [7:0]  coordX;          // Column address
    typedef logic [8:0]  coordY;          // Row address
    typedef logic [15:0] pixel565;        // RGB565 colour
    typedef logic [7:0]  cmdByte;         // Command or parameter byte
    typedef logic [15:0] busWord;         // LCD data bus word

    // Init table entry is {regSelect, byte}
    typedef logic [8:0]  initEntry;
    typedef logic [6:0]  initAddr;
    localparam int initLength = 71;       // Gamma tables left out

    localparam cmdByte cmdColumnSet = 8'h2A;
    localparam cmdByte cmdRowSet    = 8'h2B;
    localparam cmdByte cmdMemWrite  = 8'h2C;

    localparam int resetPauseMs = 120;    // Power-on pause before first write

    // Pixel FSM, each state names the next word to go out
    typedef enum logic [3:0] {
        idle,
        columnCmd,
        columnHigh,
        columnLow,
        rowCmd,
        rowHigh,
        rowLow,
        memCmd,
        pixelWord
    } pixelState;

    // Current owner of the shared write bus
    typedef enum logic [1:0] {none, init, command, pixel} grantSel;

endpackage

// File: hdl/resetSync.sv
/*
 * Reset synchroniser
 * Asserts asynchronously, releases after four clean clock edges
 */
`timescale 1ns/10ps

module resetSync (
    input  logic clock,
    input  logic resetIn,
    output logic resetOut
);

    logic [3:0] stages;    // Ones shift out towards resetOut

    always_ff @(posedge clock or posedge resetIn) begin
        if (resetIn) begin
            stages <= 4'hF;
        end else begin
            stages <= {stages[2:0], 1'b0};    // One stage clears per clock
        end
    end

    assign resetOut = stages[3];

endmodule

// File: hdl/initSequencer.sv
/*
 * Initialisation sequencer
 * Replays the init table onto the LCD bus once after reset and
 * holds the application in reset until the last entry is out
 */
`timescale 1ns/10ps

module initSequencer (
    input  logic          clock,
    input  logic          reset,
    input  logic          busReady,
    input  logic          grant,
    output logic          request,
    output logic          write,
    output logic          regSelect,
    output lcdPkg::busWord data,
    output logic          appReset
);
    import lcdPkg::*;

    `include "initTable.svh"

    initEntry romData;      // Registered table read
    initAddr  addr;         // Next entry to send
    logic     tableSent;    // Every entry issued
    logic     done;         // Last write has left the bus

    assign tableSent = (addr == initAddr'(initLength));

    // One cycle read latency, hidden by the two-cycle bus transfer
    always_ff @(posedge clock) begin
        if (!tableSent) begin
            romData <= initRom[addr];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr      <= '0;
            write     <= 1'b0;
            regSelect <= 1'b0;
            data      <= '0;
            done      <= 1'b0;
        end else begin
            write <= 1'b0;    // Single-cycle strobe
            if (grant && busReady && !tableSent) begin
                write     <= 1'b1;
                regSelect <= romData[8];
                data      <= {8'h00, romData[7:0]};
                addr      <= addr + 1'b1;
            end
            if (write && tableSent) begin
                done <= 1'b1;    // Final word now in its strobe cycle
            end
        end
    end

    assign request  = !done;             // Held from reset through the last word
    assign appReset = reset || !done;

endmodule

// File: hdl/commandPort.sv
/*
 * User command port
 * Forwards command bytes to the LCD bus, the first byte of each command
 * as a register write and the rest as parameters
 */
`timescale 1ns/10ps

module commandPort (
    input  logic           clock,
    input  logic           reset,
    input  logic           cmdWrite,
    input  logic           cmdDone,
    input  logic           busReady,
    input  logic           grant,
    input  lcdPkg::cmdByte cmdData,
    output logic           request,
    output logic           write,
    output logic           regSelect,
    output logic           cmdReady,
    output lcdPkg::busWord data
);
    import lcdPkg::*;

    logic cmdOpen;    // Command byte sent, parameters may follow

    // Request stays up while the last byte is still on the bus
    assign request = cmdWrite || cmdOpen || write;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmdOpen   <= 1'b0;
            write     <= 1'b0;
            regSelect <= 1'b0;
            cmdReady  <= 1'b0;
            data      <= '0;
        end else begin
            write    <= 1'b0;
            cmdReady <= 1'b0;
            if (grant && busReady && cmdWrite) begin
                write     <= 1'b1;
                cmdReady  <= 1'b1;          // One pulse per byte taken
                regSelect <= cmdOpen;       // Low for the command byte only
                data      <= busWord'(cmdData);
                cmdOpen   <= !cmdDone;      // cmdDone closes the command
            end
        end
    end

endmodule

// File: hdl/pixelPort.sv
/*
 * Pixel write port
 * Addressed writes set the column and row window then write one word,
 * raw writes send the colour word alone
 */
`timescale 1ns/10ps

module pixelPort (
    input  logic            clock,
    input  logic            reset,
    input  logic            pixelWrite,
    input  logic            pixelRawMode,
    input  logic            busReady,
    input  logic            grant,
    input  lcdPkg::coordX   xAddr,
    input  lcdPkg::coordY   yAddr,
    input  lcdPkg::pixel565 pixelData,
    output logic            request,
    output logic            write,
    output logic            regSelect,
    output logic            pixelReady,
    output lcdPkg::busWord  data
);
    import lcdPkg::*;

    pixelState state;
    pixelState nextState;
    busWord    column;           // Zero-extended x
    busWord    row;              // Zero-extended y
    pixel565   colour;
    busWord    nextWord;
    logic      wordIsCommand;
    logic      capture;

    assign capture = (state == idle) && pixelWrite && grant;

    // Held until the pixel word has finished its strobe
    assign request = pixelWrite || (state != idle) || write;

    // Captured coordinates and colour
    always_ff @(posedge clock) begin
        if (capture) begin
            column <= busWord'(xAddr);
            row    <= busWord'(yAddr);
            colour <= pixelData;
        end
    end

    always_comb begin
        case (state)
            columnCmd:  nextWord = busWord'(cmdColumnSet);
            columnHigh: nextWord = {8'h00, column[15:8]};
            columnLow:  nextWord = {8'h00, column[7:0]};
            rowCmd:     nextWord = busWord'(cmdRowSet);
            rowHigh:    nextWord = {8'h00, row[15:8]};
            rowLow:     nextWord = {8'h00, row[7:0]};
            memCmd:     nextWord = busWord'(cmdMemWrite);
            default:    nextWord = colour;    // pixelWord
        endcase
    end

    assign wordIsCommand = (state == columnCmd) || (state == rowCmd) || (state == memCmd);
    assign nextState     = (state == pixelWord) ? idle : pixelState'(state + 4'd1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= idle;
            write      <= 1'b0;
            regSelect  <= 1'b0;
            pixelReady <= 1'b0;
            data       <= '0;
        end else begin
            write      <= 1'b0;
            pixelReady <= 1'b0;
            if (capture) begin
                pixelReady <= 1'b1;
                state      <= pixelRawMode ? pixelWord : columnCmd;    // Raw skips the window
            end else if ((state != idle) && grant && busReady) begin
                write     <= 1'b1;
                regSelect <= !wordIsCommand;
                data      <= nextWord;
                state     <= nextState;
            end
        end
    end

endmodule

// File: hdl/busArbiter.sv
/*
 * LCD bus arbiter
 * Fixed priority init, command, pixel; an owner keeps the bus until it
 * drops request, then the bus passes through one idle cycle
 */
`timescale 1ns/10ps

module busArbiter (
    input  logic           clock,
    input  logic           reset,
    input  logic           initRequest,
    input  logic           initWrite,
    input  logic           initRegSelect,
    input  lcdPkg::busWord initData,
    input  logic           commandRequest,
    input  logic           commandWrite,
    input  logic           commandRegSelect,
    input  lcdPkg::busWord commandData,
    input  logic           pixelRequest,
    input  logic           pixelWrite,
    input  logic           pixelRegSelect,
    input  lcdPkg::busWord pixelData,
    output logic           initGrant,
    output logic           commandGrant,
    output logic           pixelGrant,
    output logic           write,
    output logic           regSelect,
    output lcdPkg::busWord data
);
    import lcdPkg::*;

    grantSel granted;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            granted <= none;
        end else begin
            case (granted)
                none: begin
                    if (initRequest) granted <= init;
                    else if (commandRequest) granted <= command;    // Command beats pixel
                    else if (pixelRequest) granted <= pixel;
                end
                init:    if (!initRequest) granted <= none;
                command: if (!commandRequest) granted <= none;
                default: if (!pixelRequest) granted <= none;
            endcase
        end
    end

    assign initGrant    = (granted == init);
    assign commandGrant = (granted == command);
    assign pixelGrant   = (granted == pixel);

    // Owner's signals to the bus timing block
    always_comb begin
        case (granted)
            init:    {write, regSelect, data} = {initWrite, initRegSelect, initData};
            command: {write, regSelect, data} = {commandWrite, commandRegSelect, commandData};
            pixel:   {write, regSelect, data} = {pixelWrite, pixelRegSelect, pixelData};
            default: {write, regSelect, data} = '0;    // Bus parked
        endcase
    end

endmodule

// File: hdl/lcdBusTiming.sv
/*
 * LCD bus timing
 * Waits out the power-on pause, then turns each write into a two-cycle
 * transfer with a one-cycle strobe on wrN
 */
`timescale 1ns/10ps

module lcdBusTiming #(
    parameter int clockFreq = 50_000_000
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           write,
    input  logic           regSelect,
    input  lcdPkg::busWord data,
    output logic           busReady,
    output logic           wrN,
    output logic           rdN,
    output logic           csN,
    output logic           rs,
    output logic           lcdResetN,
    output lcdPkg::busWord lcdData
);
    import lcdPkg::*;

    // 64-bit product, 120 ms at 50 MHz overflows an int
    localparam longint pauseCycles = (longint'(resetPauseMs) * clockFreq) / 1000;
    localparam int     pauseBits   = $clog2(pauseCycles + 1);

    logic [pauseBits-1:0] pauseCount;
    logic                 pauseDone;
    logic                 writeSecond;    // Accepted write in its strobe cycle

    assign pauseDone = (pauseCount == pauseBits'(pauseCycles));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pauseCount <= '0;
        end else if (!pauseDone) begin
            pauseCount <= pauseCount + 1'b1;    // Stops at the pause count
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            writeSecond <= 1'b0;
        end else begin
            writeSecond <= write && !writeSecond;
        end
    end

    // Not ready during the pause or in the first cycle of a write
    assign busReady = pauseDone && !(write && !writeSecond);

    assign wrN       = writeSecond;    // LCD latches on the rising edge
    assign rdN       = 1'b1;           // Write-only bus
    assign csN       = 1'b0;
    assign rs        = regSelect;
    assign lcdData   = data;
    assign lcdResetN = !reset;

endmodule

// File: hdl/lcdDisplay.sv
/*
 * LCD display driver top level
 * Init, command and pixel sources share one write bus via an arbiter
 */
`timescale 1ns/10ps

module lcdDisplay #(
    parameter int clockFreq = 50_000_000
) (
    input  logic            clock,
    input  logic            globalReset,
    input  lcdPkg::coordX   xAddr,
    input  lcdPkg::coordY   yAddr,
    input  lcdPkg::pixel565 pixelData,
    input  logic            pixelWrite,
    input  logic            pixelRawMode,
    input  lcdPkg::cmdByte  cmdData,
    input  logic            cmdWrite,
    input  logic            cmdDone,
    output logic            appReset,
    output logic            pixelReady,
    output logic            cmdReady,
    output logic            wrN,
    output logic            rdN,
    output logic            csN,
    output logic            rs,
    output logic            lcdResetN,
    output lcdPkg::busWord  lcdData,
    output logic            lcdOn
);
    import lcdPkg::*;

    logic   reset;                       // Synchronised
    logic   busReady;
    logic   initRequest, initWrite, initRegSelect, initGrant;
    logic   cmdRequest, cmdBusWrite, cmdRegSelect, cmdGrant;
    logic   pixRequest, pixBusWrite, pixRegSelect, pixGrant;
    logic   arbWrite, arbRegSelect;
    busWord initData, cmdBusData, pixBusData, arbData;

    assign lcdOn = 1'b1;    // Backlight always on

    resetSync resetGen (.clock(clock), .resetIn(globalReset), .resetOut(reset));

    initSequencer initSeq (
        .clock(clock), .reset(reset), .busReady(busReady), .grant(initGrant),
        .request(initRequest), .write(initWrite), .regSelect(initRegSelect),
        .data(initData), .appReset(appReset)
    );

    commandPort cmdPort (
        .clock(clock), .reset(reset), .cmdWrite(cmdWrite), .cmdDone(cmdDone),
        .busReady(busReady), .grant(cmdGrant), .cmdData(cmdData),
        .request(cmdRequest), .write(cmdBusWrite), .regSelect(cmdRegSelect),
        .cmdReady(cmdReady), .data(cmdBusData)
    );

    pixelPort pixPort (
        .clock(clock), .reset(reset), .pixelWrite(pixelWrite),
        .pixelRawMode(pixelRawMode), .busReady(busReady), .grant(pixGrant),
        .xAddr(xAddr), .yAddr(yAddr), .pixelData(pixelData),
        .request(pixRequest), .write(pixBusWrite), .regSelect(pixRegSelect),
        .pixelReady(pixelReady), .data(pixBusData)
    );

    busArbiter arbiter (
        .clock(clock), .reset(reset),
        .initRequest(initRequest), .initWrite(initWrite),
        .initRegSelect(initRegSelect), .initData(initData),
        .commandRequest(cmdRequest), .commandWrite(cmdBusWrite),
        .commandRegSelect(cmdRegSelect), .commandData(cmdBusData),
        .pixelRequest(pixRequest), .pixelWrite(pixBusWrite),
        .pixelRegSelect(pixRegSelect), .pixelData(pixBusData),
        .initGrant(initGrant), .commandGrant(cmdGrant), .pixelGrant(pixGrant),
        .write(arbWrite), .regSelect(arbRegSelect), .data(arbData)
    );

    lcdBusTiming #(.clockFreq(clockFreq)) busTiming (
        .clock(clock), .reset(reset), .write(arbWrite), .regSelect(arbRegSelect),
        .data(arbData), .busReady(busReady), .wrN(wrN), .rdN(rdN), .csN(csN),
        .rs(rs), .lcdResetN(lcdResetN), .lcdData(lcdData)
    );

endmodule

// File: test/lcdBus_chk.sv
/*
 * LCD bus timing checker
 * Bound into lcdBusTiming to watch write pacing, the wrN strobe and data hold
 */
`timescale 1ns/10ps

module lcdBusChk (
    input logic           clock,
    input logic           reset,
    input logic           write,
    input logic           busReady,
    input logic           wrN,
    input lcdPkg::busWord lcdData
);

    int failCount = 0;    // Assertion failures so far

    // A write only starts from a ready bus
    writeFromReady: assert property (@(posedge clock) disable iff (reset)
        write |-> $past(busReady))
        else begin
            failCount++;
            $error("write issued while the bus was not ready");
        end

    // Strobe is a single cycle
    wrNSingleCycle: assert property (@(posedge clock) disable iff (reset) wrN |=> !wrN)
        else begin
            failCount++;
            $error("wrN held high for two cycles");
        end

    // Data holds through a busy cycle
    dataHeldWhenBusy: assert property (@(posedge clock) disable iff (reset)
        !busReady |=> $stable(lcdData))
        else begin
            failCount++;
            $error("lcdData changed while the bus was busy");
        end

endmodule

bind lcdBusTiming lcdBusChk busChk (
    .clock(clock),
    .reset(reset),
    .write(write),
    .busReady(busReady),
    .wrN(wrN),
    .lcdData(lcdData)
);

// File: test/lcdDisplayTb.sv
/*
 * Testbench for the LCD display driver
 * Replays the cases file through the user ports and checks every word
 * that reaches the LCD pins
 */
`timescale 1ns/10ps

module lcdDisplayTb;
    import lcdPkg::*;

    localparam int clockFreq   = 100_000;    // 12,000 cycle pause
    localparam int clockPeriod = 10;
    localparam int pauseCycles = resetPauseMs * clockFreq / 1000;
    localparam int maxCases    = 16;
    localparam int maxBytes    = 8;
    localparam int maxWords    = 16;

    logic    clock;
    logic    globalReset;
    coordX   xAddr;
    coordY   yAddr;
    pixel565 pixelData;
    logic    pixelWrite;
    logic    pixelRawMode;
    cmdByte  cmdData;
    logic    cmdWrite;
    logic    cmdDone;
    logic    appReset, pixelReady, cmdReady;
    logic    wrN, rdN, csN, rs, lcdResetN, lcdOn;
    busWord  lcdData;

    // Case table with words packed as {rs, data}
    string       caseName [maxCases];
    string       caseKind [maxCases];
    coordX       caseX [maxCases];
    coordY       caseY [maxCases];
    pixel565     caseColour [maxCases];
    int          byteCount [maxCases];
    cmdByte      caseBytes [maxCases][maxBytes];
    int          wordCount [maxCases];
    logic [16:0] caseWords [maxCases][maxWords];
    int          caseTotal = 0;
    bit          casesLoaded = 1'b0;

    logic [16:0] captured [$];    // {rs, lcdData} once per wrN pulse
    int          pixelPulses = 0;
    int          cmdPulses = 0;
    integer      seed = 32'h0910efdc;

    lcdDisplay #(.clockFreq(clockFreq)) dut0 (
        .clock(clock), .globalReset(globalReset), .xAddr(xAddr), .yAddr(yAddr),
        .pixelData(pixelData), .pixelWrite(pixelWrite), .pixelRawMode(pixelRawMode),
        .cmdData(cmdData), .cmdWrite(cmdWrite), .cmdDone(cmdDone),
        .appReset(appReset), .pixelReady(pixelReady), .cmdReady(cmdReady),
        .wrN(wrN), .rdN(rdN), .csN(csN), .rs(rs), .lcdResetN(lcdResetN),
        .lcdData(lcdData), .lcdOn(lcdOn)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // Sampled mid-cycle, one capture per single-cycle wrN strobe
    always @(negedge clock) begin
        if (wrN) begin
            captured.push_back({rs, lcdData});
            checkPinLevel("strobe csN", 1'b0, csN);          // Chip always selected
            checkPinLevel("strobe rdN", 1'b1, rdN);
            checkPinLevel("strobe lcdOn", 1'b1, lcdOn);
            checkPinLevel("strobe lcdResetN", 1'b1, lcdResetN);
        end
        if (pixelReady) pixelPulses++;
        if (cmdReady) cmdPulses++;
        if (dut0.busTiming.busChk.failCount != 0) begin
            abortRun("A bus timing assertion failed");
        end
    end

    initial begin : watchdog
        int limitCycles;
        wait (casesLoaded);
        limitCycles = pauseCycles + 4 * (initLength + 16 * caseTotal);
        #(limitCycles * clockPeriod);
        abortRun($sformatf("Timeout after %0d cycles with the run still going", limitCycles));
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkBusWord(input string testName, input busWord expected,
                                input busWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s lcdData: expected %h, actual %h",
                               testName, expected, actual));
        end
    endtask

    task automatic checkRegSel(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s rs: expected %b, actual %b",
                               testName, expected, actual));
        end
    endtask

    task automatic checkPinLevel(input string testName, input logic expected,
                                 input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s: expected %b, actual %b",
                               testName, expected, actual));
        end
    endtask

    task automatic checkCount(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("Mismatch %s: expected %0d, actual %0d",
                               testName, expected, actual));
        end
    endtask

    task automatic loadCases();
        int    fd;
        int    got;
        int    n;
        string token;
        string line;
        n  = 0;
        fd = $fopen("test/lcd_cases.txt", "r");
        if (fd == 0) abortRun("Could not open test/lcd_cases.txt");
        while ($fscanf(fd, "%s", token) == 1) begin
            if (token[0] == "#") begin
                void'($fgets(line, fd));    // Column notes
            end else begin
                if (n == maxCases) abortRun("Too many cases in the cases file");
                caseName[n] = token;
                got = $fscanf(fd, "%s %h %h %h %d", caseKind[n], caseX[n], caseY[n],
                              caseColour[n], byteCount[n]);
                if (got != 5 || byteCount[n] > maxBytes) abortRun({"Bad case line ", token});
                if (caseKind[n] != "pixel" && caseKind[n] != "raw" &&
                    caseKind[n] != "cmd" && caseKind[n] != "both") begin
                    abortRun({"Unknown case kind in ", token});
                end
                for (int i = 0; i < byteCount[n]; i++) begin
                    void'($fscanf(fd, "%h", caseBytes[n][i]));
                end
                got = $fscanf(fd, "%d", wordCount[n]);
                if (got != 1 || wordCount[n] > maxWords) abortRun({"Bad word list in ", token});
                for (int i = 0; i < wordCount[n]; i++) begin
                    void'($fscanf(fd, "%h", caseWords[n][i]));
                end
                n++;
            end
        end
        $fclose(fd);
        if (n == 0) abortRun("The cases file holds no cases");
        caseTotal   = n;
        casesLoaded = 1'b1;
    endtask

    task automatic applyReset();
        @(posedge clock);
        globalReset <= 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        if (lcdResetN !== 1'b0) abortRun("lcdResetN was not low while reset was held");
        repeat (4) @(posedge clock);
        globalReset <= 1'b0;    // Held 8 cycles
    endtask

    task automatic checkInit();
        logic [16:0] first;
        logic [16:0] last;
        while (appReset !== 1'b0) @(negedge clock);
        @(posedge clock);    // Last init word is in the queue by now
        checkCount("init word count", initLength, captured.size());
        first = captured[0];
        last  = captured[captured.size() - 1];
        checkRegSel("init first word", 1'b0, first[16]);
        checkBusWord("init first word", 16'h00EF, first[15:0]);
        checkRegSel("init last word", 1'b0, last[16]);
        checkBusWord("init last word", 16'h0029, last[15:0]);    // Display on
    endtask

    task automatic sendPixel(input int c, input logic raw);
        @(posedge clock);
        xAddr        <= caseX[c];
        yAddr        <= caseY[c];
        pixelData    <= caseColour[c];
        pixelRawMode <= raw;
        pixelWrite   <= 1'b1;
        @(negedge clock);
        while (!pixelReady) @(negedge clock);    // Captured
        @(posedge clock);
        pixelWrite <= 1'b0;
    endtask

    task automatic sendCommand(input int c);
        for (int i = 0; i < byteCount[c]; i++) begin
            @(posedge clock);
            cmdData  <= caseBytes[c][i];
            cmdDone  <= (i == byteCount[c] - 1);    // Last byte closes it
            cmdWrite <= 1'b1;
            @(negedge clock);
            while (!cmdReady) @(negedge clock);
        end
        @(posedge clock);
        cmdWrite <= 1'b0;
        cmdDone  <= 1'b0;
    endtask

    task automatic runCase(input int c);
        int          gap;
        int          pixExpected;
        logic [16:0] got;
        @(posedge clock);
        captured.delete();
        pixelPulses = 0;
        cmdPulses   = 0;
        pixExpected = (caseKind[c] == "cmd") ? 0 : 1;
        if (caseKind[c] == "pixel") begin
            sendPixel(c, 1'b0);
        end else if (caseKind[c] == "raw") begin
            sendPixel(c, 1'b1);
        end else if (caseKind[c] == "cmd") begin
            sendCommand(c);
        end else begin
            fork    // Same cycle requests
                sendCommand(c);
                sendPixel(c, 1'b0);
            join
        end
        while (captured.size() < wordCount[c]) @(posedge clock);
        repeat (4) @(posedge clock);    // Catch any stray extra word
        checkCount({caseName[c], " word count"}, wordCount[c], captured.size());
        for (int i = 0; i < wordCount[c]; i++) begin
            got = captured[i];
            checkRegSel($sformatf("%s word %0d", caseName[c], i), caseWords[c][i][16], got[16]);
            checkBusWord($sformatf("%s word %0d", caseName[c], i), caseWords[c][i][15:0],
                         got[15:0]);
        end
        checkCount({caseName[c], " pixelReady pulses"}, pixExpected, pixelPulses);
        checkCount({caseName[c], " cmdReady pulses"}, byteCount[c], cmdPulses);
        gap = 1 + ($unsigned($random(seed)) % 8);    // Idle gap
        repeat (gap) @(posedge clock);
    endtask

    initial begin
        globalReset  = 1'b0;
        xAddr        = '0;
        yAddr        = '0;
        pixelData    = '0;
        pixelWrite   = 1'b0;
        pixelRawMode = 1'b0;
        cmdData      = '0;
        cmdWrite     = 1'b0;
        cmdDone      = 1'b0;
        loadCases();
        applyReset();
        checkInit();
        for (int c = 0; c < caseTotal; c++) begin
            runCase(c);
        end
        repeat (2) @(posedge clock);
        if (dut0.busTiming.busChk.failCount != 0) begin
            abortRun("Bus timing assertions failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: test/lcd_cases.txt
# name kind x(hex) y(hex) colour(hex) nBytes cmdBytes(hex)... nWords words...
# each word is hex {rs, data}, 1xxxx is a data word and 0xxxx a command
pixOrigin    pixel 00 000 F800 0 8 0002A 10000 10000 0002B 10000 10000 0002C 1F800
pixMiddle    pixel 78 0A0 07E0 0 8 0002A 10000 10078 0002B 10000 100A0 0002C 107E0
pixCorner    pixel EF 13F 001F 0 8 0002A 10000 100EF 0002B 10001 1003F 0002C 1001F
pixRow256    pixel 05 100 FFFF 0 8 0002A 10000 10005 0002B 10001 10000 0002C 1FFFF
rawRed       raw   00 000 F800 0 1 1F800
rawIgnoresXy raw   12 034 A5A5 0 1 1A5A5
cmdDisplayOn cmd   00 000 0000 1 29 1 00029
cmdSleepOut  cmd   00 000 0000 1 11 1 00011
cmdMadctl    cmd   00 000 0000 2 36 48 2 00036 10048
cmdColumn    cmd   00 000 0000 5 2A 00 10 00 20 5 0002A 10000 10010 10000 10020
cmdTiming    cmd   00 000 0000 4 B6 0A 82 27 4 000B6 1000A 10082 10027
bothShort    both  20 040 1234 2 36 C8 10 00036 100C8 0002A 10000 10020 0002B 10000 10040 0002C 11234
bothLong     both  EF 13F 0F0F 3 B1 00 1B 11 000B1 10000 1001B 0002A 10000 100EF 0002B 10001 1003F 0002C 10F0F
rawAfterBoth raw   00 000 0001 0 1 10001
pixOne       pixel 01 001 8410 0 8 0002A 10000 10001 0002B 10000 10001 0002C 18410

// File: sources.f
+incdir+include
hdl/lcdPkg.sv
hdl/resetSync.sv
hdl/initSequencer.sv
hdl/commandPort.sv
hdl/pixelPort.sv
hdl/busArbiter.sv
hdl/lcdBusTiming.sv
hdl/lcdDisplay.sv
test/lcdBus_chk.sv
test/lcdDisplayTb.sv

// File: Bender.yml
package:
  name: lcd_display

sources:
  - include_dirs:
      - include
    files:
      - hdl/lcdPkg.sv
      - hdl/resetSync.sv
      - hdl/initSequencer.sv
      - hdl/commandPort.sv
      - hdl/pixelPort.sv
      - hdl/busArbiter.sv
      - hdl/lcdBusTiming.sv
      - hdl/lcdDisplay.sv
  - target: test
    files:
      - test/lcdBus_chk.sv
      - test/lcdDisplayTb.sv
